/* sim.f */
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_array.sv
logic/dcache_ctrl.sv
logic/dcache.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cache and its testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module dcache_tb -f sim.f -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* bench/dcache_tb.sv */
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_tb;

  localparam dcache_pkg::word_t preload_mask = 32'hA5A5_0000;
  localparam int reset_cycles    = 5;
  localparam int req_count       = 18;   // requests issued by the tests below
  localparam int watchdog_cycles = reset_cycles + req_count * 200 + `DCACHE_SETS * 40;

  logic              CLK, nRST;
  logic              dmem_ren, dmem_wen, halt, dhit, flushed;
  dcache_pkg::word_t dmem_addr, dmem_store, dmem_load;
  logic              mem_ren, mem_wen, mem_wait;
  dcache_pkg::word_t mem_addr, mem_store, mem_load, peek_addr, peek_data;

  dcache_pkg::word_t ref_mem [dcache_pkg::word_t];  // mirror of every processor write
  dcache_pkg::word_t wr_addrs [$];                  // memory writes in issue order
  dcache_pkg::word_t wr_vals [$];
  int errors       = 0;
  int req_total    = 0;
  int served_clean = 0;                             // requests with no memory traffic
  int mem_cycles   = 0;                             // cycles with a memory request up
  string test_name = "reset";
  logic [`DCACHE_TAG_W-1:0] tag_base;

  dcache dcache_i (.*);
  dcache_mem_model #(.preload_mask(preload_mask)) mem_model_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // memory side traffic, sampled on the transfer edge
  always @(posedge CLK) begin
    if (nRST && (mem_ren || mem_wen)) mem_cycles++;
    if (nRST && mem_wen && !mem_wait) begin
      wr_addrs.push_back(mem_addr);
      wr_vals.push_back(mem_store);
    end
  end

  served_from_array: assert property (@(posedge CLK) disable iff (!nRST)
      dhit |-> !(mem_ren || mem_wen))
    else begin
      errors++;
      $display("dhit was high while a memory request was active");
    end

  quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> !(mem_ren || mem_wen))
    else begin
      errors++;
      $display("memory request issued after flushed went high");
    end

  load_zero_on_miss: assert property (@(posedge CLK) disable iff (!nRST)
      !dhit |-> (dmem_load == '0))
    else begin
      errors++;
      $display("dmem_load was not zero without dhit");
    end

  function automatic dcache_pkg::word_t make_addr(input logic [`DCACHE_TAG_W-1:0] tag,
                                                  input logic [`DCACHE_INDEX_W-1:0] idx,
                                                  input logic off);
    dcache_pkg::dcache_addr_t a;
    a.tag    = tag;
    a.idx    = idx;
    a.blkoff = off;
    a.bytoff = 2'b00;
    return dcache_pkg::word_t'(a);
  endfunction

  task automatic compare(input dcache_pkg::word_t exp, input dcache_pkg::word_t got);
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", test_name, exp, got);
    end
  endtask

  // one processor request, held until dhit
  task automatic access(input logic wr, input dcache_pkg::word_t addr,
                        input dcache_pkg::word_t data, input logic quiet,
                        output dcache_pkg::word_t got);
    int   start_cycles;
    int   wait_cycles;
    logic touched;
    @(negedge CLK);
    dmem_ren     = !wr;
    dmem_wen     = wr;
    dmem_addr    = addr;
    dmem_store   = data;
    start_cycles = mem_cycles;
    wait_cycles  = 0;
    do begin
      @(posedge CLK);
      wait_cycles++;
    end while (!dhit);
    got = dmem_load;
    @(negedge CLK);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    touched  = (mem_cycles != start_cycles);
    req_total++;
    if (!touched) served_clean++;
    assert (touched == !quiet) else begin
      errors++;
      $display("[ERROR] %s: expected memory traffic %0d, actual %0d at %h",
               test_name, !quiet, touched, addr);
    end
    // a hit answers in the cycle the request shows up
    assert (touched || (wait_cycles == 1)) else begin
      errors++;
      $display("[ERROR] %s: expected dhit after 1 cycle, actual %0d at %h",
               test_name, wait_cycles, addr);
    end
  endtask

  task automatic read_word(input dcache_pkg::word_t addr, input logic quiet);
    dcache_pkg::word_t got;
    dcache_pkg::word_t exp;
    access(1'b0, addr, '0, quiet, got);
    exp = ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ preload_mask);
    compare(exp, got);
  endtask

  task automatic write_word(input dcache_pkg::word_t addr, input dcache_pkg::word_t data,
                            input logic quiet);
    dcache_pkg::word_t got;
    access(1'b1, addr, data, quiet, got);
    ref_mem[addr] = data;
  endtask

  task automatic memory_holds(input dcache_pkg::word_t addr, input dcache_pkg::word_t exp);
    peek_addr = addr;
    #1;
    compare(exp, peek_data);
  endtask

  initial begin
    dcache_pkg::word_t r, d0, d1;
    int log_start;
    void'($urandom(32'h2249_b83b));
    nRST       = 1'b0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    dmem_addr  = '0;
    dmem_store = '0;
    halt       = 1'b0;
    peek_addr  = '0;
    r        = $urandom();
    tag_base = {1'b1, r[21:0], 3'b000};  // top bit set keeps clear of the count address
    repeat (reset_cycles) @(negedge CLK);
    assert (!mem_ren && !mem_wen && !dhit && !flushed) else begin
      errors++;
      $display("outputs not idle during reset");
    end
    nRST = 1'b1;

    test_name = "read miss then hit";
    read_word(make_addr(tag_base, 3'd1, 1'b0), 1'b0);  // fills both words
    read_word(make_addr(tag_base, 3'd1, 1'b0), 1'b1);
    read_word(make_addr(tag_base, 3'd1, 1'b1), 1'b1);

    test_name = "write hit";
    write_word(make_addr(tag_base, 3'd1, 1'b1), $urandom(), 1'b1);
    read_word(make_addr(tag_base, 3'd1, 1'b1), 1'b1);
    compare(32'd0, dcache_pkg::word_t'(wr_addrs.size()));  // still only in the cache

    test_name = "lru replacement";
    read_word(make_addr(tag_base + 26'd1, 3'd2, 1'b0), 1'b0);  // A
    read_word(make_addr(tag_base + 26'd2, 3'd2, 1'b0), 1'b0);  // B
    read_word(make_addr(tag_base + 26'd1, 3'd2, 1'b0), 1'b1);  // A again, B now lru
    read_word(make_addr(tag_base + 26'd3, 3'd2, 1'b0), 1'b0);  // C evicts B
    read_word(make_addr(tag_base + 26'd1, 3'd2, 1'b1), 1'b1);
    read_word(make_addr(tag_base + 26'd2, 3'd2, 1'b0), 1'b0);  // B has to come back

    test_name = "dirty eviction";
    d0 = $urandom();
    d1 = $urandom();
    write_word(make_addr(tag_base + 26'd4, 3'd3, 1'b0), d0, 1'b0);
    write_word(make_addr(tag_base + 26'd4, 3'd3, 1'b1), d1, 1'b1);
    read_word(make_addr(tag_base + 26'd5, 3'd3, 1'b0), 1'b0);  // fills the other way
    log_start = wr_addrs.size();
    read_word(make_addr(tag_base + 26'd6, 3'd3, 1'b0), 1'b0);  // pushes the dirty line out
    compare(dcache_pkg::word_t'(log_start + 2), dcache_pkg::word_t'(wr_addrs.size()));
    if (wr_addrs.size() == log_start + 2) begin
      compare(make_addr(tag_base + 26'd4, 3'd3, 1'b0), wr_addrs[log_start]);
      compare(d0, wr_vals[log_start]);
      compare(make_addr(tag_base + 26'd4, 3'd3, 1'b1), wr_addrs[log_start+1]);
      compare(d1, wr_vals[log_start+1]);
    end
    read_word(make_addr(tag_base + 26'd4, 3'd3, 1'b1), 1'b0);  // written word back from memory

    test_name = "flush";
    write_word(make_addr(tag_base + 26'd7, 3'd5, 1'b0), $urandom(), 1'b0);
    write_word(make_addr(tag_base + 26'd7, 3'd5, 1'b1), $urandom(), 1'b1);
    log_start = wr_addrs.size();
    @(negedge CLK);
    halt = 1'b1;
    do @(posedge CLK); while (!flushed);
    // dirty lines left in sets 1 and 5, two words each, then the count
    compare(dcache_pkg::word_t'(log_start + 5), dcache_pkg::word_t'(wr_addrs.size()));
    @(negedge CLK);
    foreach (ref_mem[a]) memory_holds(a, ref_mem[a]);
    memory_holds(`DCACHE_HITCOUNT_ADDR, dcache_pkg::word_t'(served_clean));
    repeat (10) begin
      @(posedge CLK);
      assert (flushed) else begin
        errors++;
        $display("flushed dropped after the flush finished");
      end
    end

    $display("errors: %0d, requests: %0d, served without memory: %0d",
             errors, req_total, served_clean);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("watchdog expired, a request or the flush never completed");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* bench/dcache_mem_model.sv */
`timescale 1ns/100ps

module dcache_mem_model #(
  parameter int                latency      = 2,             // wait cycles before a word completes
  parameter dcache_pkg::word_t preload_mask = 32'hA5A5_0000
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              mem_ren,
  input  logic              mem_wen,
  input  dcache_pkg::word_t mem_addr,
  input  dcache_pkg::word_t mem_store,
  output dcache_pkg::word_t mem_load,
  output logic              mem_wait,
  // side port so the bench can inspect memory contents
  input  dcache_pkg::word_t peek_addr,
  output dcache_pkg::word_t peek_data
);

  dcache_pkg::word_t words [dcache_pkg::word_t];  // only words written so far
  int                count;
  logic              active;

  // unwritten words read back as their address under the preload mask
  function automatic dcache_pkg::word_t read_mem(input dcache_pkg::word_t addr);
    if (words.exists(addr)) return words[addr];
    return addr ^ preload_mask;
  endfunction

  assign active   = mem_ren | mem_wen;
  assign mem_wait = active && (count != latency);  // low on the completing cycle

  always_comb mem_load  = mem_ren ? read_mem(mem_addr) : '0;
  always_comb peek_data = read_mem(peek_addr);

  // cycles spent on the current request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= 0;
    end else if (!active || !mem_wait) begin
      count <= 0;                      // idle, or a word just completed
    end else begin
      count <= count + 1;
    end
  end

  always @(posedge CLK) begin
    if (mem_wen && !mem_wait) words[mem_addr] = mem_store;
  end

endmodule

/* logic/dcache.sv */
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache (
  input  logic               CLK,
  input  logic               nRST,
  // processor data port
  input  logic               dmem_ren,
  input  logic               dmem_wen,
  input  dcache_pkg::word_t  dmem_addr,
  input  dcache_pkg::word_t  dmem_store,
  input  logic               halt,
  output logic               dhit,
  output dcache_pkg::word_t  dmem_load,
  output logic               flushed,
  // word memory
  input  dcache_pkg::word_t  mem_load,
  input  logic               mem_wait,
  output logic               mem_ren,
  output logic               mem_wen,
  output dcache_pkg::word_t  mem_addr,
  output dcache_pkg::word_t  mem_store
);

  // lookup path from array to controller
  dcache_pkg::dcache_frame_t  frame0, frame1;
  logic                       hit, hit_way, lru_way;
  logic [`DCACHE_INDEX_W-1:0] index;
  logic [`DCACHE_TAG_W-1:0]   tag;

  // write and lru path from controller to array
  logic                       wr_en, wr_way, wr_word;
  dcache_pkg::word_t          wr_data;
  logic [`DCACHE_TAG_W-1:0]   wr_tag;
  logic                       wr_valid, wr_dirty;
  logic                       lru_en, lru_used_way;

  dcache_ctrl ctrl_i (
    .CLK, .nRST,
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
    .dhit, .dmem_load, .flushed,
    .mem_load, .mem_wait, .mem_ren, .mem_wen, .mem_addr, .mem_store,
    .frame0, .frame1, .hit, .hit_way, .lru_way,
    .index, .tag,
    .wr_en, .wr_way, .wr_word, .wr_data, .wr_tag, .wr_valid, .wr_dirty,
    .lru_en, .lru_used_way
  );

  dcache_array array_i (
    .CLK, .nRST,
    .index, .tag,
    .wr_en, .wr_way, .wr_word, .wr_data, .wr_tag, .wr_valid, .wr_dirty,
    .lru_en, .lru_used_way,
    .frame0, .frame1, .hit, .hit_way, .lru_way
  );

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                        CLK,
  input  logic                        nRST,
  // processor side
  input  logic                        dmem_ren,
  input  logic                        dmem_wen,
  input  dcache_pkg::word_t           dmem_addr,
  input  dcache_pkg::word_t           dmem_store,
  input  logic                        halt,
  output logic                        dhit,
  output dcache_pkg::word_t           dmem_load,
  output logic                        flushed,
  // memory side
  input  dcache_pkg::word_t           mem_load,
  input  logic                        mem_wait,
  output logic                        mem_ren,
  output logic                        mem_wen,
  output dcache_pkg::word_t           mem_addr,
  output dcache_pkg::word_t           mem_store,
  // array lookup
  input  dcache_pkg::dcache_frame_t   frame0,
  input  dcache_pkg::dcache_frame_t   frame1,
  input  logic                        hit,
  input  logic                        hit_way,
  input  logic                        lru_way,
  output logic [`DCACHE_INDEX_W-1:0]  index,
  output logic [`DCACHE_TAG_W-1:0]    tag,
  // array write and lru
  output logic                        wr_en,
  output logic                        wr_way,
  output logic                        wr_word,
  output dcache_pkg::word_t           wr_data,
  output logic [`DCACHE_TAG_W-1:0]    wr_tag,
  output logic                        wr_valid,
  output logic                        wr_dirty,
  output logic                        lru_en,
  output logic                        lru_used_way
);

  dcache_pkg::dcache_state_t state, next_state;
  dcache_pkg::dcache_addr_t  req_addr;
  dcache_pkg::dcache_frame_t hit_frame, victim, flush_frame;

  logic                       req;
  logic                       flushing;      // index comes from the flush counter
  logic [`DCACHE_INDEX_W-1:0] flush_idx;
  logic                       flush_adv;     // last step of a set is done
  logic                       step_done;     // current flush step may move on
  dcache_pkg::word_t          hit_count;
  logic                       missed;        // this request already went to memory
  logic                       miss_start;

  assign req_addr = dcache_pkg::dcache_addr_t'(dmem_addr);
  assign req      = dmem_ren | dmem_wen;

  assign flushing = (state == dcache_pkg::flush1) || (state == dcache_pkg::flush2) ||
                    (state == dcache_pkg::flush3) || (state == dcache_pkg::flush4);

  assign index = flushing ? flush_idx : req_addr.idx;
  assign tag   = req_addr.tag;

  assign hit_frame   = hit_way ? frame1 : frame0;
  assign victim      = lru_way ? frame1 : frame0;  // replacement candidate
  assign flush_frame = ((state == dcache_pkg::flush1) ||
                        (state == dcache_pkg::flush2)) ? frame0 : frame1;

  // load data only while hitting
  assign dmem_load = dhit ? hit_frame.block[req_addr.blkoff] : '0;

  // a clean step has no request so mem_wait is ignored
  assign step_done = !flush_frame.dirty || !mem_wait;

  always_comb begin
    next_state   = state;
    dhit         = 1'b0;
    flushed      = 1'b0;
    mem_ren      = 1'b0;
    mem_wen      = 1'b0;
    mem_addr     = '0;
    mem_store    = '0;
    wr_en        = 1'b0;
    wr_way       = lru_way;           // fills go to the victim
    wr_word      = 1'b0;
    wr_data      = mem_load;
    wr_tag       = req_addr.tag;
    wr_valid     = 1'b0;
    wr_dirty     = 1'b0;
    lru_en       = 1'b0;
    lru_used_way = hit_way;
    flush_adv    = 1'b0;
    miss_start   = 1'b0;

    unique case (state)
      dcache_pkg::idle: begin
        if (req && hit) begin
          dhit   = 1'b1;
          lru_en = 1'b1;
          if (dmem_wen) begin         // write hit updates one word
            wr_en    = 1'b1;
            wr_way   = hit_way;
            wr_word  = req_addr.blkoff;
            wr_data  = dmem_store;
            wr_valid = 1'b1;
            wr_dirty = 1'b1;
          end
        end
        if (halt) begin
          next_state = dcache_pkg::flush1;
        end else if (req && !hit) begin
          miss_start = 1'b1;
          if (victim.valid && victim.dirty) begin
            next_state = dcache_pkg::wb1;
          end else begin
            next_state = dcache_pkg::fetch1;
          end
        end
      end

      dcache_pkg::wb1: begin
        mem_wen   = 1'b1;
        mem_addr  = {victim.tag, req_addr.idx, 1'b0, 2'b00};
        mem_store = victim.block[0];
        if (!mem_wait) next_state = dcache_pkg::wb2;
      end

      dcache_pkg::wb2: begin
        mem_wen   = 1'b1;
        mem_addr  = {victim.tag, req_addr.idx, 1'b1, 2'b00};
        mem_store = victim.block[1];
        if (!mem_wait) next_state = dcache_pkg::fetch1;
      end

      dcache_pkg::fetch1: begin
        mem_ren  = 1'b1;
        mem_addr = {req_addr.tag, req_addr.idx, 1'b0, 2'b00};
        wr_en    = !mem_wait;         // capture the word as it completes
        wr_word  = 1'b0;
        if (!mem_wait) next_state = dcache_pkg::fetch2;
      end

      dcache_pkg::fetch2: begin
        mem_ren  = 1'b1;
        mem_addr = {req_addr.tag, req_addr.idx, 1'b1, 2'b00};
        wr_en    = !mem_wait;
        wr_word  = 1'b1;
        wr_valid = 1'b1;              // line usable from the next cycle
        if (!mem_wait) next_state = dcache_pkg::idle;
      end

      dcache_pkg::flush1, dcache_pkg::flush2,
      dcache_pkg::flush3, dcache_pkg::flush4: begin
        // odd steps take the low word and even steps the high word
        mem_wen   = flush_frame.dirty;
        mem_addr  = {flush_frame.tag, flush_idx,
                     (state == dcache_pkg::flush2) || (state == dcache_pkg::flush4),
                     2'b00};
        mem_store = ((state == dcache_pkg::flush2) || (state == dcache_pkg::flush4)) ?
                    flush_frame.block[1] : flush_frame.block[0];
        if (step_done) begin
          unique case (state)
            dcache_pkg::flush1: next_state = dcache_pkg::flush2;
            dcache_pkg::flush2: next_state = dcache_pkg::flush3;
            dcache_pkg::flush3: next_state = dcache_pkg::flush4;
            default: begin
              if (flush_idx == `DCACHE_INDEX_W'(`DCACHE_SETS - 1)) begin
                next_state = dcache_pkg::flush_count;
              end else begin
                flush_adv  = 1'b1;    // on to the next set
                next_state = dcache_pkg::flush1;
              end
            end
          endcase
        end
      end

      dcache_pkg::flush_count: begin
        mem_wen   = 1'b1;
        mem_addr  = `DCACHE_HITCOUNT_ADDR;
        mem_store = hit_count;
        if (!mem_wait) next_state = dcache_pkg::flushed;
      end

      default: begin
        flushed = 1'b1;               // stays here until reset
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= dcache_pkg::idle;
    end else begin
      state <= next_state;
    end
  end

  // set walk counter for the flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      flush_idx <= '0;
    end else if (flush_adv) begin
      flush_idx <= flush_idx + 1'b1;
    end
  end

  // hits counted only for requests served without memory traffic
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      hit_count <= '0;
      missed    <= 1'b0;
    end else if (dhit) begin
      if (!missed) hit_count <= hit_count + 32'd1;
      missed <= 1'b0;                 // request retires here
    end else if (miss_start) begin
      missed <= 1'b1;
    end
  end

endmodule

/* logic/dcache_array.sv */
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_array (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic [`DCACHE_INDEX_W-1:0]  index,
  input  logic [`DCACHE_TAG_W-1:0]    tag,
  input  logic                        wr_en,
  input  logic                        wr_way,
  input  logic                        wr_word,
  input  dcache_pkg::word_t           wr_data,
  input  logic [`DCACHE_TAG_W-1:0]    wr_tag,
  input  logic                        wr_valid,
  input  logic                        wr_dirty,
  input  logic                        lru_en,
  input  logic                        lru_used_way,
  output dcache_pkg::dcache_frame_t   frame0,
  output dcache_pkg::dcache_frame_t   frame1,
  output logic                        hit,
  output logic                        hit_way,
  output logic                        lru_way
);

  // storage split so only the flag bits carry a reset
  logic [`DCACHE_TAG_W-1:0] tag_mem [2][`DCACHE_SETS];
  dcache_pkg::word_t [`DCACHE_BLOCK_WORDS-1:0] data_mem [2][`DCACHE_SETS];

  logic [`DCACHE_SETS-1:0] valid [2];
  logic [`DCACHE_SETS-1:0] dirty [2];
  logic [`DCACHE_SETS-1:0] lru;        // per set, the way to replace next

  logic hit0, hit1;

  // tag and data write port, one word per cycle
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      tag_mem[wr_way][index]           <= wr_tag;
      data_mem[wr_way][index][wr_word] <= wr_data;
    end
  end

  // valid and dirty follow the same write port
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid[0] <= '0;
      valid[1] <= '0;
      dirty[0] <= '0;
      dirty[1] <= '0;
    end else if (wr_en) begin
      valid[wr_way][index] <= wr_valid;
      dirty[wr_way][index] <= wr_dirty;
    end
  end

  // touching a way makes the other one least recently used
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lru <= '0;
    end else if (lru_en) begin
      lru[index] <= ~lru_used_way;
    end
  end

  // both frames of the addressed set
  always_comb begin
    frame0.tag   = tag_mem[0][index];
    frame0.block = data_mem[0][index];
    frame0.valid = valid[0][index];
    frame0.dirty = dirty[0][index];
    frame1.tag   = tag_mem[1][index];
    frame1.block = data_mem[1][index];
    frame1.valid = valid[1][index];
    frame1.dirty = dirty[1][index];
  end

  // raw tag match against valid ways only
  assign hit0 = frame0.valid && (frame0.tag == tag);
  assign hit1 = frame1.valid && (frame1.tag == tag);

  assign hit     = hit0 | hit1;
  assign hit_way = hit1;           // tags never match in both ways
  assign lru_way = lru[index];

endmodule

/* logic/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

  // one data or address word
  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // byte address as the cache sees it
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0]   tag;     // upper bits
    logic [`DCACHE_INDEX_W-1:0] idx;     // set select
    logic                       blkoff;  // word within block
    logic [1:0]                 bytoff;  // always zero for word access
  } dcache_addr_t;

  // one way of one set
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0]            tag;
    word_t [`DCACHE_BLOCK_WORDS-1:0]     block;  // block[1] is the high word
    logic                                valid;
    logic                                dirty;
  } dcache_frame_t;

  // controller states
  typedef enum logic [3:0] {
    idle,
    fetch1, fetch2,                  // fill word 0 then word 1
    wb1, wb2,                        // victim write-back
    flush1, flush2, flush3, flush4,  // way 0 lo/hi, way 1 lo/hi
    flush_count,                     // hit count to memory
    flushed                          // parked until reset
  } dcache_state_t;

endpackage

/* logic/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DCACHE_SETS         8   // sets per way
`define DCACHE_INDEX_W      3   // log2 of the set count
`define DCACHE_BLOCK_WORDS  2   // words per block

// address split
// the tag takes what is left above index, block offset and byte offset
`define DCACHE_TAG_W        26

// data path
`define DCACHE_WORD_W       32  // processor and memory word

// after the flush walk the hit count lands here
`define DCACHE_HITCOUNT_ADDR 32'h3100

`endif
